// ==== axi_lite_mem_top.f ====
axi_pkg.sv
axi_lite_to_axi.sv
axi_mem_slave.sv
axi_lite_mem_top.sv
axi_lite_mem_asserts.sv
tb_axi_lite_mem_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the AXI-Lite memory subsystem testbench with Verilator and runs it.
# Exits with status 0 only when the simulation prints its pass line.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_lite_mem_top -f axi_lite_mem_top.f -o tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '>>> PASS'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb_axi_lite_mem_top.sv ====
/*
  Testbench for the AXI-Lite memory subsystem.
  First fills every memory word through the AXI-Lite write channels. Then it
  runs random writes and reads in two concurrent threads, each with its own
  xorshift stream. A monitor keeps a reference copy of the memory, predicts
  every B and R response and checks the values and the one-cycle latency.
*/
`timescale 1ns/1ps
module tb_axi_lite_mem_top;

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH   = 4;
  localparam int MAX_TXNS   = 2;
  localparam int MEM_WORDS  = 256;
  localparam int BYTES      = DATA_WIDTH / 8;
  localparam int IDX_W      = $clog2(MEM_WORDS);
  localparam logic [31:0] SEED = 32'd15971;
  localparam int NUM_WR     = 300;
  localparam int NUM_RD     = 300;
  // Random traffic folds onto a few words so that reads often hit fresh writes
  localparam int HOT_WORDS  = 32;
  // Twenty cycles for every transaction including the fill pass
  localparam int TIMEOUT_CYCLES = (MEM_WORDS + NUM_WR + NUM_RD) * 20;

  logic                    clk;
  logic                    arst_n;
  logic [ADDR_WIDTH-1:0]   aw_addr;
  logic [2:0]              aw_prot;
  logic                    aw_valid;
  logic                    aw_ready;
  logic [DATA_WIDTH-1:0]   w_data;
  logic [BYTES-1:0]        w_strb;
  logic                    w_valid;
  logic                    w_ready;
  axi_pkg::resp_t          b_resp;
  logic                    b_valid;
  logic                    b_ready;
  logic [ADDR_WIDTH-1:0]   ar_addr;
  logic [2:0]              ar_prot;
  logic                    ar_valid;
  logic                    ar_ready;
  logic [DATA_WIDTH-1:0]   r_data;
  axi_pkg::resp_t          r_resp;
  logic                    r_valid;
  logic                    r_ready;

  logic [31:0]             wr_rng;
  logic [31:0]             rd_rng;
  // Reference copy of the memory that is updated when a write request completes
  logic [DATA_WIDTH-1:0]   model [MEM_WORDS];
  logic [ADDR_WIDTH-1:0]   mon_aw_addr;
  logic [DATA_WIDTH-1:0]   mon_w_data;
  logic [BYTES-1:0]        mon_w_strb;
  bit                      mon_have_aw;
  bit                      mon_have_w;
  bit                      b_pending;
  bit                      r_pending;
  bit                      b_due;
  bit                      r_due;
  axi_pkg::resp_t          exp_b_resp;
  axi_pkg::resp_t          exp_r_resp;
  logic [DATA_WIDTH-1:0]   exp_r_data;
  int                      b_seen;
  int                      r_seen;
  int                      cycles;

  axi_lite_mem_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MAX_TXNS   (MAX_TXNS),
    .MEM_WORDS  (MEM_WORDS)
  ) uut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic bit addr_in_range(input logic [ADDR_WIDTH-1:0] a);
    return (a / BYTES) < MEM_WORDS;
  endfunction

  function automatic logic [IDX_W-1:0] word_index(input logic [ADDR_WIDTH-1:0] a);
    return IDX_W'(a / BYTES);
  endfunction

  // About one address in ten lies beyond the memory
  function automatic logic [ADDR_WIDTH-1:0] pick_addr(input logic [31:0] r);
    if (r % 10 == 0) begin
      return ADDR_WIDTH'((MEM_WORDS + (r >> 8) % 4096) * BYTES);
    end
    return ADDR_WIDTH'(((r >> 8) % HOT_WORDS) * BYTES);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic compare_resp(input string name, input axi_pkg::resp_t exp,
                              input axi_pkg::resp_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error at %0d ns: %s expected %s, got %s (%b)",
                          $time, name, exp.name(), act.name(), act));
    end
  endtask

  task automatic compare_data(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Error at %0d ns: %s expected 0x%h, got 0x%h",
                          $time, name, exp, act));
    end
  endtask

  // Order 0 sends AW first, order 1 sends W first, order 2 sends both at once.
  // The payload is set before any valid rises, so it stays stable
  task automatic write_txn(input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] data,
                           input logic [BYTES-1:0] strb, input int order);
    bit aw_done = 1'b0;
    bit w_done = 1'b0;
    bit b_done = 1'b0;
    @(posedge clk);
    aw_addr  <= addr;
    aw_prot  <= wr_rng[2:0];
    w_data   <= data;
    w_strb   <= strb;
    aw_valid <= (order != 1);
    w_valid  <= (order != 0);
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (aw_valid && aw_ready) begin
        aw_valid <= 1'b0;
        aw_done = 1'b1;
        // The second half goes out right after the first one is taken
        if (!w_done && !w_valid) begin
          w_valid <= 1'b1;
        end
      end
      if (w_valid && w_ready) begin
        w_valid <= 1'b0;
        w_done = 1'b1;
        if (!aw_done && !aw_valid) begin
          aw_valid <= 1'b1;
        end
      end
    end
    // b_ready is low about one edge in three
    while (!b_done) begin
      @(posedge clk);
      b_done = b_valid && b_ready;
      wr_rng = xorshift32(wr_rng);
      b_ready <= !b_done && (wr_rng % 3 != 0);
    end
  endtask

  task automatic read_txn(input logic [ADDR_WIDTH-1:0] addr);
    bit r_done = 1'b0;
    @(posedge clk);
    ar_addr  <= addr;
    ar_prot  <= rd_rng[2:0];
    ar_valid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!ar_ready);
    ar_valid <= 1'b0;
    while (!r_done) begin
      @(posedge clk);
      r_done = r_valid && r_ready;
      rd_rng = xorshift32(rd_rng);
      r_ready <= !r_done && (rd_rng % 3 != 0);
    end
  endtask

  task automatic random_writes();
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    for (int n = 0; n < NUM_WR; n++) begin
      wr_rng = xorshift32(wr_rng);
      addr = pick_addr(wr_rng);
      wr_rng = xorshift32(wr_rng);
      data = wr_rng;
      wr_rng = xorshift32(wr_rng);
      write_txn(addr, data, BYTES'(wr_rng), int'(wr_rng[15:8] % 3));
    end
  endtask

  task automatic random_reads();
    for (int n = 0; n < NUM_RD; n++) begin
      rd_rng = xorshift32(rd_rng);
      read_txn(pick_addr(rd_rng));
    end
  endtask

  // Monitor and reference model. It samples the ports at the rising edge,
  // before the edge's own updates, so it sees exactly what the DUT sees
  always @(posedge clk) begin
    logic [IDX_W-1:0] idx;
    if (arst_n) begin
      if (b_due && !b_valid) begin
        abort_run("b_valid did not rise one cycle after the write request completed");
      end
      if (r_due && !r_valid) begin
        abort_run("r_valid did not rise one cycle after the read address handshake");
      end
      if (b_valid && !b_pending) begin
        abort_run("b_valid is high with no completed write request");
      end
      if (r_valid && !r_pending) begin
        abort_run("r_valid is high with no accepted read address");
      end
      b_due = 1'b0;
      r_due = 1'b0;
      if (b_valid && b_ready) begin
        compare_resp("b_resp", exp_b_resp, b_resp);
        b_pending = 1'b0;
        b_seen++;
      end
      if (r_valid && r_ready) begin
        compare_resp("r_resp", exp_r_resp, r_resp);
        compare_data("r_data", exp_r_data, r_data);
        r_pending = 1'b0;
        r_seen++;
      end
      // A read taken on the same edge as a write commit still sees the old word
      if (ar_valid && ar_ready) begin
        if (addr_in_range(ar_addr)) begin
          exp_r_data = model[word_index(ar_addr)];
          exp_r_resp = axi_pkg::OKAY;
        end else begin
          exp_r_data = '0;
          exp_r_resp = axi_pkg::DECERR;
        end
        r_pending = 1'b1;
        r_due = 1'b1;
      end
      if (aw_valid && aw_ready) begin
        mon_aw_addr = aw_addr;
        mon_have_aw = 1'b1;
      end
      if (w_valid && w_ready) begin
        mon_w_data = w_data;
        mon_w_strb = w_strb;
        mon_have_w = 1'b1;
      end
      if (mon_have_aw && mon_have_w) begin
        exp_b_resp = axi_pkg::DECERR;
        if (addr_in_range(mon_aw_addr)) begin
          idx = word_index(mon_aw_addr);
          for (int i = 0; i < BYTES; i++) begin
            if (mon_w_strb[i]) begin
              model[idx][i*8 +: 8] = mon_w_data[i*8 +: 8];
            end
          end
          exp_b_resp = axi_pkg::OKAY;
        end
        mon_have_aw = 1'b0;
        mon_have_w = 1'b0;
        b_pending = 1'b1;
        b_due = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: the run hangs, not finished after %0d cycles", cycles));
    end
  end

  initial begin
    clk      = 1'b0;
    arst_n   = 1'b0;
    aw_addr  = '0;
    aw_prot  = '0;
    aw_valid = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_addr  = '0;
    ar_prot  = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    wr_rng   = SEED;
    // The read stream starts from a scrambled copy of the seed
    rd_rng   = SEED ^ 32'h5bd1_e995;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    // Give every word a known value before any read
    for (int i = 0; i < MEM_WORDS; i++) begin
      wr_rng = xorshift32(wr_rng);
      write_txn(ADDR_WIDTH'(i * BYTES), wr_rng, '1, i % 3);
    end
    fork
      random_writes();
      random_reads();
    join
    @(posedge clk);
    if (b_seen == MEM_WORDS + NUM_WR && r_seen == NUM_RD) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run($sformatf("Response count is wrong: %0d B and %0d R seen", b_seen, r_seen));
    end
  end

endmodule

// ==== axi_lite_mem_asserts.sv ====
/*
  Handshake assertions for the AXI-Lite memory subsystem.
  Bound into every axi_lite_mem_top instance. Checks that held responses
  keep their payload, that the subsystem comes out of reset idle, and that
  the converter never exceeds its outstanding limit.
*/
`timescale 1ns/1ps
module axi_lite_mem_asserts #(
  parameter int DATA_WIDTH = 32,
  parameter int MAX_TXNS   = 2,
  localparam int CNT_W     = $clog2(MAX_TXNS + 1)
) (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  b_valid,
  input logic                  b_ready,
  input axi_pkg::resp_t        b_resp,
  input logic                  r_valid,
  input logic                  r_ready,
  input logic [DATA_WIDTH-1:0] r_data,
  input axi_pkg::resp_t        r_resp,
  input axi_pkg::wr_state_t    wr_state,
  input logic [CNT_W-1:0]      wr_outstanding,
  input logic [CNT_W-1:0]      rd_outstanding
);

  // A stalled response keeps valid and payload until the master takes it
  b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    b_valid && !b_ready |=> b_valid && $stable(b_resp))
    else $error("B response dropped or changed before b_ready");

  r_hold: assert property (@(posedge clk) disable iff (!arst_n)
    r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_resp))
    else $error("R response dropped or changed before r_ready");

  reset_idle: assert property (@(posedge clk)
    $rose(arst_n) |-> !b_valid && !r_valid && wr_state == axi_pkg::W_IDLE)
    else $error("Subsystem not idle when reset was released");

  txn_limit: assert property (@(posedge clk) disable iff (!arst_n)
    wr_outstanding <= CNT_W'(MAX_TXNS) && rd_outstanding <= CNT_W'(MAX_TXNS))
    else $error("Outstanding transaction count above its limit");

endmodule

bind axi_lite_mem_top axi_lite_mem_asserts #(
  .DATA_WIDTH (DATA_WIDTH),
  .MAX_TXNS   (MAX_TXNS)
) u_asserts (
  .clk, .arst_n,
  .b_valid, .b_ready, .b_resp,
  .r_valid, .r_ready, .r_data, .r_resp,
  .wr_state       (u_mem.wr_state),
  .wr_outstanding (u_conv.wr_outstanding),
  .rd_outstanding (u_conv.rd_outstanding)
);

// ==== axi_lite_mem_top.sv ====
/*
  AXI-Lite memory subsystem top level.
  Joins the AXI-Lite to AXI converter and the AXI memory slave over an
  internal single-beat AXI link and sets the parameters of both. A write
  answers one cycle after its later address/data handshake, a read one
  cycle after its address handshake.
*/
`timescale 1ns/1ps
module axi_lite_mem_top #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int MAX_TXNS   = 2,
  parameter int MEM_WORDS  = 256
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [ADDR_WIDTH-1:0]     aw_addr,
  input  logic [2:0]                aw_prot,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  logic [DATA_WIDTH-1:0]     w_data,
  input  logic [DATA_WIDTH/8-1:0]   w_strb,
  input  logic                      w_valid,
  output logic                      w_ready,
  output axi_pkg::resp_t            b_resp,
  output logic                      b_valid,
  input  logic                      b_ready,
  input  logic [ADDR_WIDTH-1:0]     ar_addr,
  input  logic [2:0]                ar_prot,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  output logic [DATA_WIDTH-1:0]     r_data,
  output axi_pkg::resp_t            r_resp,
  output logic                      r_valid,
  input  logic                      r_ready
);

  // Internal AXI link with the converter as master and the memory as slave
  logic [ADDR_WIDTH-1:0]   m_aw_addr, m_ar_addr;
  logic [2:0]              m_aw_prot, m_ar_prot;
  logic [ID_WIDTH-1:0]     m_aw_id, m_ar_id, m_b_id, m_r_id;
  logic                    m_aw_valid, m_aw_ready, m_ar_valid, m_ar_ready;
  logic [DATA_WIDTH-1:0]   m_w_data, m_r_data;
  logic [DATA_WIDTH/8-1:0] m_w_strb;
  logic                    m_w_valid, m_w_ready;
  axi_pkg::resp_t          m_b_resp, m_r_resp;
  logic                    m_b_valid, m_b_ready, m_r_valid, m_r_ready;

  axi_lite_to_axi #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MAX_TXNS   (MAX_TXNS)
  ) u_conv (
    .clk, .arst_n,
    .aw_addr, .aw_prot, .aw_valid, .aw_ready,
    .w_data, .w_strb, .w_valid, .w_ready,
    .b_resp, .b_valid, .b_ready,
    .ar_addr, .ar_prot, .ar_valid, .ar_ready,
    .r_data, .r_resp, .r_valid, .r_ready,
    .m_aw_addr, .m_aw_prot, .m_aw_id, .m_aw_valid, .m_aw_ready,
    .m_w_data, .m_w_strb, .m_w_valid, .m_w_ready,
    .m_b_id, .m_b_resp, .m_b_valid, .m_b_ready,
    .m_ar_addr, .m_ar_prot, .m_ar_id, .m_ar_valid, .m_ar_ready,
    .m_r_id, .m_r_data, .m_r_resp, .m_r_valid, .m_r_ready
  );

  axi_mem_slave #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MEM_WORDS  (MEM_WORDS)
  ) u_mem (
    .clk, .arst_n,
    .m_aw_addr, .m_aw_prot, .m_aw_id, .m_aw_valid, .m_aw_ready,
    .m_w_data, .m_w_strb, .m_w_valid, .m_w_ready,
    .m_b_id, .m_b_resp, .m_b_valid, .m_b_ready,
    .m_ar_addr, .m_ar_prot, .m_ar_id, .m_ar_valid, .m_ar_ready,
    .m_r_id, .m_r_data, .m_r_resp, .m_r_valid, .m_r_ready
  );

endmodule

// ==== axi_mem_slave.sv ====
/*
  Single-beat AXI memory slave.
  Holds MEM_WORDS data words indexed by the word address. Writes apply
  their byte strobes and reads return the whole word. Addresses beyond the
  array answer DECERR, leave the memory unchanged and read as zero.
  Write and read channels have their own state machines and echo the
  request ID in the response one cycle after the request completes.
*/
`timescale 1ns/1ps
module axi_mem_slave #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int MEM_WORDS  = 256
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [ADDR_WIDTH-1:0]     m_aw_addr,
  input  logic [2:0]                m_aw_prot,
  input  logic [ID_WIDTH-1:0]       m_aw_id,
  input  logic                      m_aw_valid,
  output logic                      m_aw_ready,
  input  logic [DATA_WIDTH-1:0]     m_w_data,
  input  logic [DATA_WIDTH/8-1:0]   m_w_strb,
  input  logic                      m_w_valid,
  output logic                      m_w_ready,
  output logic [ID_WIDTH-1:0]       m_b_id,
  output axi_pkg::resp_t            m_b_resp,
  output logic                      m_b_valid,
  input  logic                      m_b_ready,
  input  logic [ADDR_WIDTH-1:0]     m_ar_addr,
  input  logic [2:0]                m_ar_prot,
  input  logic [ID_WIDTH-1:0]       m_ar_id,
  input  logic                      m_ar_valid,
  output logic                      m_ar_ready,
  output logic [ID_WIDTH-1:0]       m_r_id,
  output logic [DATA_WIDTH-1:0]     m_r_data,
  output axi_pkg::resp_t            m_r_resp,
  output logic                      m_r_valid,
  input  logic                      m_r_ready
);

  localparam int STRB_W = DATA_WIDTH / 8;
  localparam int BYTE_SHIFT = $clog2(STRB_W);
  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  axi_pkg::wr_state_t    wr_state;
  axi_pkg::rd_state_t    rd_state;
  logic [ADDR_WIDTH-1:0] aw_addr_q;
  logic [ID_WIDTH-1:0]   aw_id_q;
  logic [DATA_WIDTH-1:0] w_data_q;
  logic [STRB_W-1:0]     w_strb_q;
  axi_pkg::resp_t        b_resp_q;
  logic [ID_WIDTH-1:0]   r_id_q;
  logic [DATA_WIDTH-1:0] r_data_q;
  axi_pkg::resp_t        r_resp_q;
  logic                  aw_hs, w_hs, ar_hs;
  logic                  wr_commit;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [STRB_W-1:0]     wr_strb;
  logic                  wr_hit, rd_hit;

  // True when the byte address falls inside the array
  function automatic logic in_range(input logic [ADDR_WIDTH-1:0] addr);
    return (addr >> BYTE_SHIFT) < ADDR_WIDTH'(MEM_WORDS);
  endfunction

  function automatic logic [IDX_W-1:0] word_idx(input logic [ADDR_WIDTH-1:0] addr);
    return IDX_W'(addr >> BYTE_SHIFT);
  endfunction

  // Each address/data channel stays ready until its half has been latched
  assign m_aw_ready = (wr_state == axi_pkg::W_IDLE) || (wr_state == axi_pkg::W_HAVE_W);
  assign m_w_ready  = (wr_state == axi_pkg::W_IDLE) || (wr_state == axi_pkg::W_HAVE_AW);
  assign m_ar_ready = (rd_state == axi_pkg::R_IDLE);

  assign aw_hs = m_aw_valid && m_aw_ready;
  assign w_hs  = m_w_valid && m_w_ready;
  assign ar_hs = m_ar_valid && m_ar_ready;

  // The write completes in the cycle the later half arrives
  assign wr_commit = (aw_hs && w_hs) ||
                     (aw_hs && wr_state == axi_pkg::W_HAVE_W) ||
                     (w_hs && wr_state == axi_pkg::W_HAVE_AW);

  // Take each half from the bus when it arrives now, otherwise from its latch
  assign wr_addr = aw_hs ? m_aw_addr : aw_addr_q;
  assign wr_data = w_hs ? m_w_data : w_data_q;
  assign wr_strb = w_hs ? m_w_strb : w_strb_q;
  assign wr_hit  = in_range(wr_addr);
  assign rd_hit  = in_range(m_ar_addr);

  assign m_b_valid = (wr_state == axi_pkg::W_RESP);
  assign m_b_id    = aw_id_q;
  assign m_b_resp  = b_resp_q;

  assign m_r_valid = (rd_state == axi_pkg::R_RESP);
  assign m_r_id    = r_id_q;
  assign m_r_data  = r_data_q;
  assign m_r_resp  = r_resp_q;

  // Protection bits are accepted on both address channels but every level
  // is granted the same access, so m_aw_prot and m_ar_prot only arrive here

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_state <= axi_pkg::W_IDLE;
    end else begin
      case (wr_state)
        axi_pkg::W_IDLE: begin
          if (wr_commit) begin
            wr_state <= axi_pkg::W_RESP;
          end else if (aw_hs) begin
            wr_state <= axi_pkg::W_HAVE_AW;
          end else if (w_hs) begin
            wr_state <= axi_pkg::W_HAVE_W;
          end
        end
        axi_pkg::W_HAVE_AW, axi_pkg::W_HAVE_W: begin
          if (wr_commit) begin
            wr_state <= axi_pkg::W_RESP;
          end
        end
        default: begin
          if (m_b_ready) begin
            wr_state <= axi_pkg::W_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_addr_q <= m_aw_addr;
      aw_id_q   <= m_aw_id;
    end
    if (w_hs) begin
      w_data_q <= m_w_data;
      w_strb_q <= m_w_strb;
    end
    if (wr_commit) begin
      b_resp_q <= wr_hit ? axi_pkg::OKAY : axi_pkg::DECERR;
    end
  end

  // Byte lanes without a strobe keep their old contents
  always_ff @(posedge clk) begin
    if (wr_commit && wr_hit) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr_strb[i]) begin
          mem[word_idx(wr_addr)][i*8 +: 8] <= wr_data[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_state <= axi_pkg::R_IDLE;
    end else if (rd_state == axi_pkg::R_IDLE) begin
      if (ar_hs) begin
        rd_state <= axi_pkg::R_RESP;
      end
    end else if (m_r_ready) begin
      rd_state <= axi_pkg::R_IDLE;
    end
  end

  // Read data is sampled when AR is taken and held until the R handshake
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      r_id_q   <= m_ar_id;
      r_data_q <= rd_hit ? mem[word_idx(m_ar_addr)] : '0;
      r_resp_q <= rd_hit ? axi_pkg::OKAY : axi_pkg::DECERR;
    end
  end

endmodule

// ==== axi_lite_to_axi.sv ====
/*
  AXI-Lite to single-beat AXI converter.
  Address, data and response paths are combinational and add no latency.
  Every accepted write or read is tagged with a rolling ID, one counter per
  direction, and address acceptance stops while MAX_TXNS transactions of
  that direction are outstanding. A response whose ID does not match the
  oldest outstanding ID is turned into SLVERR.
*/
`timescale 1ns/1ps
module axi_lite_to_axi #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int MAX_TXNS   = 2
) (
  input  logic                      clk,
  input  logic                      arst_n,
  // AXI-Lite slave side
  input  logic [ADDR_WIDTH-1:0]     aw_addr,
  input  logic [2:0]                aw_prot,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  logic [DATA_WIDTH-1:0]     w_data,
  input  logic [DATA_WIDTH/8-1:0]   w_strb,
  input  logic                      w_valid,
  output logic                      w_ready,
  output axi_pkg::resp_t            b_resp,
  output logic                      b_valid,
  input  logic                      b_ready,
  input  logic [ADDR_WIDTH-1:0]     ar_addr,
  input  logic [2:0]                ar_prot,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  output logic [DATA_WIDTH-1:0]     r_data,
  output axi_pkg::resp_t            r_resp,
  output logic                      r_valid,
  input  logic                      r_ready,
  // AXI master side
  output logic [ADDR_WIDTH-1:0]     m_aw_addr,
  output logic [2:0]                m_aw_prot,
  output logic [ID_WIDTH-1:0]       m_aw_id,
  output logic                      m_aw_valid,
  input  logic                      m_aw_ready,
  output logic [DATA_WIDTH-1:0]     m_w_data,
  output logic [DATA_WIDTH/8-1:0]   m_w_strb,
  output logic                      m_w_valid,
  input  logic                      m_w_ready,
  input  logic [ID_WIDTH-1:0]       m_b_id,
  input  axi_pkg::resp_t            m_b_resp,
  input  logic                      m_b_valid,
  output logic                      m_b_ready,
  output logic [ADDR_WIDTH-1:0]     m_ar_addr,
  output logic [2:0]                m_ar_prot,
  output logic [ID_WIDTH-1:0]       m_ar_id,
  output logic                      m_ar_valid,
  input  logic                      m_ar_ready,
  input  logic [ID_WIDTH-1:0]       m_r_id,
  input  logic [DATA_WIDTH-1:0]     m_r_data,
  input  axi_pkg::resp_t            m_r_resp,
  input  logic                      m_r_valid,
  output logic                      m_r_ready
);

  localparam int CNT_W = $clog2(MAX_TXNS + 1);

  // Issue counters hold the ID that the next request will carry
  logic [ID_WIDTH-1:0] wr_id_q, rd_id_q;
  logic [CNT_W-1:0]    wr_outstanding, rd_outstanding;
  logic                wr_full, rd_full;
  logic                aw_hs, b_hs, ar_hs, r_hs;
  logic [ID_WIDTH-1:0] wr_exp_id, rd_exp_id;

  assign wr_full = (wr_outstanding >= CNT_W'(MAX_TXNS));
  assign rd_full = (rd_outstanding >= CNT_W'(MAX_TXNS));

  // A full direction hides the request from the slave and stalls the master
  assign m_aw_addr  = aw_addr;
  assign m_aw_prot  = aw_prot;
  assign m_aw_id    = wr_id_q;
  assign m_aw_valid = aw_valid && !wr_full;
  assign aw_ready   = m_aw_ready && !wr_full;

  // Write data is not counted, so it passes straight through
  assign m_w_data  = w_data;
  assign m_w_strb  = w_strb;
  assign m_w_valid = w_valid;
  assign w_ready   = m_w_ready;

  assign m_ar_addr  = ar_addr;
  assign m_ar_prot  = ar_prot;
  assign m_ar_id    = rd_id_q;
  assign m_ar_valid = ar_valid && !rd_full;
  assign ar_ready   = m_ar_ready && !rd_full;

  assign aw_hs = m_aw_valid && m_aw_ready;
  assign ar_hs = m_ar_valid && m_ar_ready;
  assign b_hs  = m_b_valid && b_ready;
  assign r_hs  = m_r_valid && r_ready;

  // Responses come back in order, so the oldest one in flight was issued
  // as many IDs ago as there are outstanding transactions
  assign wr_exp_id = wr_id_q - ID_WIDTH'(wr_outstanding);
  assign rd_exp_id = rd_id_q - ID_WIDTH'(rd_outstanding);

  assign b_valid   = m_b_valid;
  assign b_resp    = (m_b_id == wr_exp_id) ? m_b_resp : axi_pkg::SLVERR;
  assign m_b_ready = b_ready;

  assign r_valid   = m_r_valid;
  assign r_data    = m_r_data;
  assign r_resp    = (m_r_id == rd_exp_id) ? m_r_resp : axi_pkg::SLVERR;
  assign m_r_ready = r_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_id_q        <= '0;
      rd_id_q        <= '0;
      wr_outstanding <= '0;
      rd_outstanding <= '0;
    end else begin
      if (aw_hs) begin
        wr_id_q <= wr_id_q + 1'b1;
      end
      if (ar_hs) begin
        rd_id_q <= rd_id_q + 1'b1;
      end
      // An issue and a retire in the same cycle leave the count unchanged
      if (aw_hs && !b_hs) begin
        wr_outstanding <= wr_outstanding + 1'b1;
      end else if (!aw_hs && b_hs) begin
        wr_outstanding <= wr_outstanding - 1'b1;
      end
      if (ar_hs && !r_hs) begin
        rd_outstanding <= rd_outstanding + 1'b1;
      end else if (!ar_hs && r_hs) begin
        rd_outstanding <= rd_outstanding - 1'b1;
      end
    end
  end

endmodule

// ==== axi_pkg.sv ====
/*
  Shared types for the AXI-Lite memory subsystem.
  Holds the AXI response encoding and the state encodings of the memory
  slave's write and read state machines. Files refer to these types by
  scoped names such as axi_pkg::resp_t.
*/
package axi_pkg;

  // AXI response codes with their bus encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  // Write channel states of the memory slave
  // W_HAVE_AW and W_HAVE_W mean that one half of the request is latched
  // and the slave still waits for the other half
  typedef enum logic [1:0] {
    W_IDLE    = 2'b00,
    W_HAVE_AW = 2'b01,
    W_HAVE_W  = 2'b10,
    W_RESP    = 2'b11
  } wr_state_t;

  // Read channel states of the memory slave
  typedef enum logic {
    R_IDLE = 1'b0,
    R_RESP = 1'b1
  } rd_state_t;

endpackage
